/* verilog/gsu_defs.svh */
`ifndef GSU_DEFS_SVH
`define GSU_DEFS_SVH

// ----------------------------------------------------------
// Sizes
// ----------------------------------------------------------
`define GSU_NUM_GPR     16
// Cache index width, 512 bytes
`define GSU_CACHE_AW    9

// ----------------------------------------------------------
// Host window offsets, low 10 address bits
// ----------------------------------------------------------
`define GSU_ADDR_SFR    10'h030
`define GSU_ADDR_VCR    10'h03B
`define GSU_VCR_RESET   8'd4
// Cache window 0x100..0x2FF
`define GSU_ADDR_CACHE  10'h100

// ----------------------------------------------------------
// Opcodes
// ----------------------------------------------------------
`define GSU_OP_STOP     8'h00
`define GSU_OP_NOP      8'h01
// High-nibble groups, low nibble is the register
`define GSU_OP_TO       4'h1
`define GSU_OP_ADD      4'h5
`define GSU_OP_SUB      4'h6
`define GSU_OP_IBT      4'hA
`define GSU_OP_FROM     4'hB

`endif

/* verilog/gsu_pkg.sv */
`include "gsu_defs.svh"

package gsu_pkg;

  // Micro-op kinds seen past decode
  typedef enum logic [2:0] {
    OP_NOP  = 3'd0,
    OP_STOP = 3'd1,
    OP_ADD  = 3'd2,
    OP_SUB  = 3'd3,
    OP_IBT  = 3'd4
  } gsu_op_e;

  // Status flags, same meaning as the SFR bits
  typedef struct packed {
    logic z;
    logic cy;
    logic s;
    logic ov;
  } gsu_flags_t;

  // One decoded instruction
  typedef struct packed {
    gsu_op_e                  op;
    logic [3:0]               dreg;
    logic [3:0]               sreg;
    logic [3:0]               oreg;
    // Already sign-extended
    logic [15:0]              imm;
    // Address after the instruction
    logic [`GSU_CACHE_AW-1:0] next_pc;
  } gsu_uop_t;

  // Retire record back into the register file
  typedef struct packed {
    logic                     wr;
    logic                     setf;
    logic                     stop;
    logic [3:0]               dreg;
    logic [15:0]              value;
    gsu_flags_t               flags;
    logic [`GSU_CACHE_AW-1:0] pc;
  } gsu_wb_t;

endpackage

/* verilog/gsu_cache.sv */
`timescale 1ns/100ps
`include "gsu_defs.svh"

module gsu_cache (
  input  logic                     CLK,
  // Host side
  input  logic                     a_wr,
  input  logic [`GSU_CACHE_AW-1:0] a_addr,
  input  logic [7:0]               a_wdata,
  output logic [7:0]               a_rdata,
  // Instruction fetch side
  input  logic [`GSU_CACHE_AW-1:0] b_addr,
  output logic [7:0]               b_rdata
);

  logic [7:0] mem [0:(1 << `GSU_CACHE_AW) - 1];

  // Host port, read gives the old byte on a write
  always_ff @(posedge CLK) begin
    if (a_wr) begin
      mem[a_addr] <= a_wdata;
    end
    a_rdata <= mem[a_addr];
  end

  // Fetch port, read only
  always_ff @(posedge CLK) begin
    b_rdata <= mem[b_addr];
  end

endmodule

/* verilog/gsu_regs.sv */
`timescale 1ns/100ps
`include "gsu_defs.svh"

module gsu_regs (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     ENABLE,
  input  logic                     SNES_RD_start,
  input  logic                     SNES_WR_end,
  input  logic [23:0]              SNES_ADDR,
  input  logic [7:0]               DATA_IN,
  output logic                     DATA_ENABLE,
  output logic [7:0]               DATA_OUT,
  output logic                     cache_wr,
  output logic [`GSU_CACHE_AW-1:0] cache_addr,
  output logic [7:0]               cache_wdata,
  input  logic [7:0]               cache_rdata,
  output logic                     go,
  output logic [`GSU_CACHE_AW-1:0] r15,
  input  logic [3:0]               rd_a_idx,
  input  logic [3:0]               rd_b_idx,
  output logic [15:0]              rd_a,
  output logic [15:0]              rd_b,
  input  gsu_pkg::gsu_wb_t         wb,
  input  logic                     wb_valid
);
  import gsu_pkg::*;

  logic [15:0]              gpr [`GSU_NUM_GPR];
  gsu_flags_t               flags;
  logic [7:0]               lo_hold;
  logic [7:0]               data_out_r;
  logic                     de_r;
  logic                     rd_pend;
  logic                     out_cache;
  logic [9:0]               offs;
  logic                     is_gpr;
  logic                     is_cache;
  logic [3:0]               gidx;
  logic [`GSU_CACHE_AW-1:0] cidx;
  logic [7:0]               sfr_lo;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  assign offs     = SNES_ADDR[9:0];
  assign is_gpr   = (offs < 10'(2 * `GSU_NUM_GPR));
  assign is_cache = (offs >= `GSU_ADDR_CACHE) && (offs < `GSU_ADDR_CACHE + 10'h200);
  // Two bytes per register, bit 0 picks the byte
  assign gidx     = offs[4:1];
  // 0x100..0x2FF folds onto cache 0..0x1FF
  assign cidx     = {~offs[8], offs[7:0]};
  assign sfr_lo   = {2'b00, go, flags.ov, flags.s, flags.cy, flags.z, 1'b0};

  assign rd_a        = gpr[rd_a_idx];
  assign rd_b        = gpr[rd_b_idx];
  assign r15         = gpr[15][`GSU_CACHE_AW-1:0];
  assign DATA_ENABLE = de_r;
  // Cache reads answer straight from the RAM output
  assign DATA_OUT    = out_cache ? cache_rdata : data_out_r;

  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int i = 0; i < `GSU_NUM_GPR; i++) begin
        gpr[i] <= '0;
      end
      flags     <= '0;
      go        <= 1'b0;
      de_r      <= 1'b0;
      rd_pend   <= 1'b0;
      out_cache <= 1'b0;
      cache_wr  <= 1'b0;
    end else begin
      // Cache read data lands a cycle after the address
      de_r      <= rd_pend;
      out_cache <= rd_pend;
      rd_pend   <= 1'b0;
      cache_wr  <= 1'b0;

      // Host reads, only SFR and VCR while running
      if (ENABLE && SNES_RD_start) begin
        if (is_gpr && !go) begin
          de_r       <= 1'b1;
          data_out_r <= offs[0] ? gpr[gidx][15:8] : gpr[gidx][7:0];
        end else if (offs == `GSU_ADDR_SFR) begin
          de_r       <= 1'b1;
          data_out_r <= sfr_lo;
        end else if (offs == `GSU_ADDR_SFR + 10'h001) begin
          // Upper SFR bits not modelled
          de_r       <= 1'b1;
          data_out_r <= 8'h00;
        end else if (offs == `GSU_ADDR_VCR) begin
          de_r       <= 1'b1;
          data_out_r <= `GSU_VCR_RESET;
        end else if (is_cache && !go) begin
          cache_addr <= cidx;
          rd_pend    <= 1'b1;
        end
      end

      // Host writes
      if (ENABLE && SNES_WR_end) begin
        if (is_gpr && !go) begin
          // Low byte waits for the high byte
          if (!offs[0]) begin
            lo_hold <= DATA_IN;
          end else begin
            gpr[gidx] <= {DATA_IN, lo_hold};
          end
        end else if (offs == `GSU_ADDR_SFR) begin
          go       <= DATA_IN[5];
          flags.z  <= DATA_IN[1];
          flags.cy <= DATA_IN[2];
          flags.s  <= DATA_IN[3];
          flags.ov <= DATA_IN[4];
        end else if (is_cache && !go) begin
          cache_wr    <= 1'b1;
          cache_addr  <= cidx;
          cache_wdata <= DATA_IN;
        end
      end

      // ----------------------------------------------------------
      // Core writeback, wins over the host
      // ----------------------------------------------------------
      if (wb_valid) begin
        if (wb.wr) begin
          gpr[wb.dreg] <= wb.value;
        end
        if (wb.setf) begin
          flags <= wb.flags;
        end
        if (wb.stop) begin
          go <= 1'b0;
        end
        // R15 tracks the retired address, over any register write
        gpr[15] <= 16'(wb.pc);
      end
    end
  end

endmodule

/* verilog/gsu_decode.sv */
`timescale 1ns/100ps
`include "gsu_defs.svh"

module gsu_decode (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     go,
  input  logic [`GSU_CACHE_AW-1:0] r15,
  output logic [`GSU_CACHE_AW-1:0] fetch_addr,
  input  logic [7:0]               fetch_data,
  output gsu_pkg::gsu_uop_t        uop,
  output logic                     uop_valid
);
  import gsu_pkg::*;

  logic [`GSU_CACHE_AW-1:0] pc;
  logic                     go_d;
  logic                     running;
  logic                     byte_valid;
  logic                     imm_pend;
  logic [3:0]               to_r;
  logic [3:0]               from_r;
  logic [3:0]               ibt_dreg;
  logic [3:0]               grp;
  logic                     dec_issue;
  gsu_uop_t                 dec;

  // Streamed fetch, byte for pc-1 arrives while pc is on the bus
  assign fetch_addr = pc;
  assign grp        = fetch_data[7:4];

  // ----------------------------------------------------------
  // Byte decode
  // ----------------------------------------------------------
  always_comb begin
    dec = '{op: OP_NOP, dreg: to_r, sreg: from_r, oreg: fetch_data[3:0],
            imm: {{8{fetch_data[7]}}, fetch_data}, next_pc: pc};
    dec_issue = 1'b1;
    if (imm_pend) begin
      // Second byte of IBT
      dec.op   = OP_IBT;
      dec.dreg = ibt_dreg;
    end else begin
      case (grp)
        `GSU_OP_TO, `GSU_OP_FROM, `GSU_OP_IBT: dec_issue = 1'b0;
        `GSU_OP_ADD: dec.op = OP_ADD;
        `GSU_OP_SUB: dec.op = OP_SUB;
        default: begin
          // Anything outside the subset is skipped
          if (fetch_data == `GSU_OP_STOP) dec.op = OP_STOP;
          else if (fetch_data != `GSU_OP_NOP) dec_issue = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      pc         <= '0;
      go_d       <= 1'b0;
      running    <= 1'b0;
      byte_valid <= 1'b0;
      imm_pend   <= 1'b0;
      to_r       <= 4'd0;
      from_r     <= 4'd0;
      uop_valid  <= 1'b0;
    end else begin
      go_d      <= go;
      uop_valid <= 1'b0;
      if (go && !go_d) begin
        // New run from R15
        pc         <= r15;
        running    <= 1'b1;
        byte_valid <= 1'b0;
        imm_pend   <= 1'b0;
        to_r       <= 4'd0;
        from_r     <= 4'd0;
      end else if (!go || !running) begin
        // Abort, or parked after STOP
        running    <= 1'b0;
        byte_valid <= 1'b0;
      end else begin
        pc         <= pc + 1'b1;
        byte_valid <= 1'b1;
        if (byte_valid) begin
          if (!imm_pend && grp == `GSU_OP_TO) to_r <= fetch_data[3:0];
          if (!imm_pend && grp == `GSU_OP_FROM) from_r <= fetch_data[3:0];
          if (!imm_pend && grp == `GSU_OP_IBT) ibt_dreg <= fetch_data[3:0];
          imm_pend <= !imm_pend && (grp == `GSU_OP_IBT);
          if (dec_issue) begin
            uop       <= dec;
            uop_valid <= 1'b1;
            // Prefixes last one instruction
            to_r      <= 4'd0;
            from_r    <= 4'd0;
            if (dec.op == OP_STOP) begin
              running    <= 1'b0;
              byte_valid <= 1'b0;
            end
          end
        end
      end
    end
  end

endmodule

/* verilog/gsu_execute.sv */
`timescale 1ns/100ps

module gsu_execute (
  input  logic                CLK,
  input  logic                RST,
  input  gsu_pkg::gsu_uop_t   uop,
  input  logic                uop_valid,
  output logic [3:0]          rd_a_idx,
  output logic [3:0]          rd_b_idx,
  input  logic [15:0]         rd_a,
  input  logic [15:0]         rd_b,
  input  gsu_pkg::gsu_wb_t    wb,
  input  logic                wb_valid,
  output gsu_pkg::gsu_uop_t   ex_uop,
  output logic [15:0]         ex_value,
  output gsu_pkg::gsu_flags_t ex_flags,
  output logic                ex_valid
);
  import gsu_pkg::*;

  logic [15:0] opa;
  logic [15:0] opb;
  logic [15:0] res;
  logic [16:0] sum;
  logic [16:0] diff;
  gsu_flags_t  flg;

  // Forward the record in writeback, same order as the register file
  function automatic logic [15:0] bypass(input logic [3:0] idx, input logic [15:0] rf);
    if (wb_valid && idx == 4'd15) return 16'(wb.pc);
    if (wb_valid && wb.wr && wb.dreg == idx) return wb.value;
    return rf;
  endfunction

  assign rd_a_idx = uop.sreg;
  assign rd_b_idx = uop.oreg;
  assign opa      = bypass(rd_a_idx, rd_a);
  assign opb      = bypass(rd_b_idx, rd_b);
  assign sum      = {1'b0, opa} + {1'b0, opb};
  assign diff     = {1'b0, opa} - {1'b0, opb};

  // ----------------------------------------------------------
  // ALU and flags
  // ----------------------------------------------------------
  always_comb begin
    case (uop.op)
      OP_ADD:  res = sum[15:0];
      OP_SUB:  res = diff[15:0];
      OP_IBT:  res = uop.imm;
      default: res = opa;
    endcase
    flg.z  = (res == 16'h0000);
    flg.s  = res[15];
    // SUB carry means no borrow
    flg.cy = (uop.op == OP_SUB) ? ~diff[16] : sum[16];
    // Signed overflow, operand signs vs result sign
    flg.ov = (uop.op == OP_SUB) ? ((opa[15] ^ opb[15]) & (res[15] ^ opa[15]))
                                : (~(opa[15] ^ opb[15]) & (res[15] ^ opa[15]));
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= uop_valid;
    end
    ex_uop   <= uop;
    ex_value <= res;
    ex_flags <= flg;
  end

endmodule

/* verilog/gsu_result.sv */
`timescale 1ns/100ps

module gsu_result (
  input  logic                CLK,
  input  logic                RST,
  input  logic                go,
  input  gsu_pkg::gsu_uop_t   ex_uop,
  input  logic [15:0]         ex_value,
  input  gsu_pkg::gsu_flags_t ex_flags,
  input  logic                ex_valid,
  output gsu_pkg::gsu_wb_t    wb,
  output logic                wb_valid,
  output logic                ACTIVE
);
  import gsu_pkg::*;

  logic go_d;
  logic is_alu;

  // Retire record, presented in the cycle after execute
  assign is_alu   = (ex_uop.op == OP_ADD) || (ex_uop.op == OP_SUB);
  assign wb.wr    = is_alu || (ex_uop.op == OP_IBT);
  assign wb.setf  = is_alu;
  assign wb.stop  = (ex_uop.op == OP_STOP);
  assign wb.dreg  = ex_uop.dreg;
  assign wb.value = ex_value;
  assign wb.flags = ex_flags;
  assign wb.pc    = ex_uop.next_pc;
  assign wb_valid = ex_valid;

  // Busy from GO pickup to STOP retire or abort
  always_ff @(posedge CLK) begin
    if (RST) begin
      go_d   <= 1'b0;
      ACTIVE <= 1'b0;
    end else begin
      go_d <= go;
      if ((wb_valid && wb.stop) || !go) begin
        ACTIVE <= 1'b0;
      end else if (go && !go_d) begin
        ACTIVE <= 1'b1;
      end
    end
  end

endmodule

/* verilog/gsu.sv */
`timescale 1ns/100ps
`include "gsu_defs.svh"

module gsu (
  input  logic        RST,
  input  logic        CLK,
  input  logic        ENABLE,
  input  logic        SNES_RD_start,
  input  logic        SNES_WR_end,
  input  logic [23:0] SNES_ADDR,
  input  logic [7:0]  DATA_IN,
  output logic        DATA_ENABLE,
  output logic [7:0]  DATA_OUT,
  output logic        ACTIVE
);
  import gsu_pkg::*;

  // Cache ports
  logic                     cache_wr;
  logic [`GSU_CACHE_AW-1:0] cache_addr;
  logic [7:0]               cache_wdata;
  logic [7:0]               cache_rdata;
  logic [`GSU_CACHE_AW-1:0] fetch_addr;
  logic [7:0]               fetch_data;
  // Control and register read
  logic                     go;
  logic [`GSU_CACHE_AW-1:0] r15;
  logic [3:0]               rd_a_idx;
  logic [3:0]               rd_b_idx;
  logic [15:0]              rd_a;
  logic [15:0]              rd_b;
  // Pipeline
  gsu_uop_t                 uop;
  logic                     uop_valid;
  gsu_uop_t                 ex_uop;
  logic [15:0]              ex_value;
  gsu_flags_t               ex_flags;
  logic                     ex_valid;
  gsu_wb_t                  wb;
  logic                     wb_valid;

  gsu_regs u_regs (.CLK, .RST, .ENABLE, .SNES_RD_start, .SNES_WR_end, .SNES_ADDR,
                   .DATA_IN, .DATA_ENABLE, .DATA_OUT, .cache_wr, .cache_addr,
                   .cache_wdata, .cache_rdata, .go, .r15, .rd_a_idx, .rd_b_idx,
                   .rd_a, .rd_b, .wb, .wb_valid);

  gsu_cache u_cache (.CLK, .a_wr(cache_wr), .a_addr(cache_addr), .a_wdata(cache_wdata),
                     .a_rdata(cache_rdata), .b_addr(fetch_addr), .b_rdata(fetch_data));

  gsu_decode u_decode (.CLK, .RST, .go, .r15, .fetch_addr, .fetch_data, .uop, .uop_valid);

  gsu_execute u_execute (.CLK, .RST, .uop, .uop_valid, .rd_a_idx, .rd_b_idx, .rd_a, .rd_b,
                         .wb, .wb_valid, .ex_uop, .ex_value, .ex_flags, .ex_valid);

  gsu_result u_result (.CLK, .RST, .go, .ex_uop, .ex_value, .ex_flags, .ex_valid,
                       .wb, .wb_valid, .ACTIVE);

endmodule

/* bench/gsu_tb.sv */
`timescale 1ns/100ps
`include "gsu_defs.svh"

module gsu_tb;

  localparam int NUM_PROGS  = 8;
  localparam int MAX_BYTES  = 32;
  localparam int FILL_BYTES = 1 << `GSU_CACHE_AW;
  // About 40 cycles per program byte plus setup margin
  localparam int TIMEOUT_CYCLES = 40 * (NUM_PROGS * MAX_BYTES + FILL_BYTES) + 2000;

  logic        CLK;
  logic        RST;
  logic        ENABLE;
  logic        SNES_RD_start;
  logic        SNES_WR_end;
  logic [23:0] SNES_ADDR;
  logic [7:0]  DATA_IN;
  logic        DATA_ENABLE;
  logic [7:0]  DATA_OUT;
  logic        ACTIVE;

  logic [31:0] lcg_state;
  int          cycles = 0;
  logic [7:0]  prog [MAX_BYTES];
  logic [15:0] exp_regs [`GSU_NUM_GPR];
  // Packed as z, cy, s, ov
  logic [3:0]  exp_flags;

  gsu uut (.RST, .CLK, .ENABLE, .SNES_RD_start, .SNES_WR_end, .SNES_ADDR, .DATA_IN,
           .DATA_ENABLE, .DATA_OUT, .ACTIVE);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // ----------------------------------------------------------
  // Failure reporting and checks
  // ----------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  // Hard stop for a hung run
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles", cycles));
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // Upper bits since the low ones cycle too fast
    return lcg_state >> 16;
  endfunction

  // ----------------------------------------------------------
  // Host bus
  // ----------------------------------------------------------
  task automatic host_write(input logic [9:0] offs, input logic [7:0] data);
    @(posedge CLK);
    #2;
    SNES_ADDR   = {14'h0, offs};
    DATA_IN     = data;
    SNES_WR_end = 1'b1;
    @(posedge CLK);
    #2;
    SNES_WR_end = 1'b0;
  endtask

  task automatic host_read(input logic [9:0] offs, output logic [7:0] data);
    int waited;
    @(posedge CLK);
    #2;
    SNES_ADDR     = {14'h0, offs};
    SNES_RD_start = 1'b1;
    @(posedge CLK);
    #2;
    SNES_RD_start = 1'b0;
    waited = 0;
    // Sample mid-cycle since DATA_ENABLE is a registered pulse
    @(negedge CLK);
    while (!DATA_ENABLE) begin
      waited++;
      if (waited > 8) begin
        abort_run($sformatf("No read response from offset %h", offs));
      end
      @(negedge CLK);
    end
    data = DATA_OUT;
  endtask

  task automatic write_word(input logic [3:0] n, input logic [15:0] val);
    host_write({5'd0, n, 1'b0}, val[7:0]);
    host_write({5'd0, n, 1'b1}, val[15:8]);
  endtask

  task automatic read_word(input logic [3:0] n, output logic [15:0] val);
    logic [7:0] lo;
    logic [7:0] hi;
    host_read({5'd0, n, 1'b0}, lo);
    host_read({5'd0, n, 1'b1}, hi);
    val = {hi, lo};
  endtask

  task automatic wait_active(input logic level, input int limit);
    int waited;
    waited = 0;
    @(negedge CLK);
    while (ACTIVE !== level) begin
      waited++;
      if (waited > limit) begin
        abort_run($sformatf("ACTIVE did not reach %0b within %0d cycles", level, limit));
      end
      @(negedge CLK);
    end
  endtask

  // ----------------------------------------------------------
  // Program generator and reference model
  // ----------------------------------------------------------
  // Narrow picks R0..R3 only so results feed each other
  function automatic int make_prog(input bit narrow);
    int         len;
    int         target;
    int         kind;
    logic [3:0] n;
    logic [3:0] grp_tab [5];
    grp_tab = '{`GSU_OP_IBT, `GSU_OP_ADD, `GSU_OP_SUB, `GSU_OP_TO, `GSU_OP_FROM};
    len = 0;
    target = 8 + int'(lcg_next() % 20);
    while (len < target) begin
      n = 4'(lcg_next() % (narrow ? 4 : 15));
      kind = int'(lcg_next() % 6);
      prog[len] = (kind == 5) ? `GSU_OP_NOP : {grp_tab[kind], n};
      if (kind == 0) begin
        prog[len + 1] = 8'(lcg_next());
        len++;
      end
      len++;
    end
    prog[len] = `GSU_OP_STOP;
    return len + 1;
  endfunction

  // Runs the program over exp_regs and exp_flags
  function automatic void ref_run(input int len, input logic [8:0] base);
    int          pc;
    int          wide;
    bit          done;
    logic [3:0]  grp;
    logic [3:0]  n;
    logic [3:0]  to_r;
    logic [3:0]  from_r;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    pc = 0;
    done = 1'b0;
    to_r = 4'd0;
    from_r = 4'd0;
    while (!done && pc < len) begin
      grp = prog[pc][7:4];
      n = prog[pc][3:0];
      case (grp)
        4'h1: to_r = n;
        4'hB: from_r = n;
        4'hA: begin
          pc++;
          exp_regs[n] = {{8{prog[pc][7]}}, prog[pc]};
        end
        4'h5, 4'h6: begin
          a = exp_regs[from_r];
          b = exp_regs[n];
          if (grp == 4'h5) begin
            res = a + b;
            exp_flags[2] = (32'(a) + 32'(b)) > 32'hFFFF;
            wide = int'($signed(a)) + int'($signed(b));
          end else begin
            res = a - b;
            // Carry set when nothing was borrowed
            exp_flags[2] = (a >= b);
            wide = int'($signed(a)) - int'($signed(b));
          end
          exp_flags[3] = (res == 16'h0);
          exp_flags[1] = res[15];
          exp_flags[0] = (wide > 32767) || (wide < -32768);
          exp_regs[to_r] = res;
        end
        default: done = (prog[pc] == `GSU_OP_STOP);
      endcase
      // Prefixes reach only the next instruction
      if (grp != 4'h1 && grp != 4'hB) begin
        to_r = 4'd0;
        from_r = 4'd0;
      end
      pc++;
    end
    exp_regs[15] = 16'(base) + 16'(pc);
  endfunction

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    logic [7:0]  b;
    logic [7:0]  got8;
    logic [15:0] w;
    logic [8:0]  base;
    int          len;
    lcg_state     = 32'd30308;
    RST           = 1'b1;
    ENABLE        = 1'b1;
    SNES_RD_start = 1'b0;
    SNES_WR_end   = 1'b0;
    SNES_ADDR     = 24'h0;
    DATA_IN       = 8'h00;
    repeat (16) @(posedge CLK);
    #2;
    RST = 1'b0;

    // Reset state
    check_val("ACTIVE", 16'(ACTIVE), 16'h0);
    host_read(`GSU_ADDR_VCR, b);
    check_val("VCR", 16'(b), 16'h0004);
    host_read(`GSU_ADDR_SFR, b);
    check_val("SFR", 16'(b), 16'h0);
    for (int r = 0; r < `GSU_NUM_GPR; r++) begin
      read_word(4'(r), w);
      check_val($sformatf("R%0d", r), w, 16'h0);
    end

    // Register and cache readback
    for (int r = 0; r < `GSU_NUM_GPR; r++) begin
      exp_regs[r] = 16'(lcg_next());
      write_word(4'(r), exp_regs[r]);
      read_word(4'(r), w);
      check_val($sformatf("R%0d", r), w, exp_regs[r]);
    end
    for (int i = 0; i < 16; i++) begin
      base = 9'(lcg_next());
      b = 8'(lcg_next());
      host_write(10'(`GSU_ADDR_CACHE + base), b);
      host_read(10'(`GSU_ADDR_CACHE + base), got8);
      check_val($sformatf("cache[%h]", base), 16'(got8), 16'(b));
    end

    // Random programs
    for (int p = 0; p < NUM_PROGS; p++) begin
      len = make_prog(p[0]);
      base = 9'(lcg_next() % 400);
      for (int i = 0; i < len; i++) begin
        host_write(10'(`GSU_ADDR_CACHE + base + i), prog[i]);
      end
      for (int r = 0; r < 15; r++) begin
        exp_regs[r] = 16'(lcg_next());
        write_word(4'(r), exp_regs[r]);
      end
      write_word(4'd15, 16'(base));
      // GO write also clears the flags
      exp_flags = 4'h0;
      ref_run(len, base);
      host_write(`GSU_ADDR_SFR, 8'h20);
      wait_active(1'b1, 8);
      wait_active(1'b0, 40 * len);
      for (int r = 0; r < `GSU_NUM_GPR; r++) begin
        read_word(4'(r), w);
        check_val($sformatf("prog %0d R%0d", p, r), w, exp_regs[r]);
      end
      host_read(`GSU_ADDR_SFR, b);
      check_val($sformatf("prog %0d SFR", p), 16'(b),
                16'({3'b000, exp_flags[0], exp_flags[1], exp_flags[2], exp_flags[3], 1'b0}));
    end

    // Endless run of ADDs so the fetch pointer wraps around the cache
    for (int a = 0; a < FILL_BYTES; a++) begin
      host_write(10'(`GSU_ADDR_CACHE + a), {`GSU_OP_ADD, 4'((a ^ (a >> 4) ^ (a >> 7)) % 15)});
    end
    host_write(`GSU_ADDR_SFR, 8'h20);
    wait_active(1'b1, 8);
    repeat (FILL_BYTES + 100) @(posedge CLK);
    #2;
    check_val("ACTIVE", 16'(ACTIVE), 16'h1);
    host_write(`GSU_ADDR_SFR, 8'h00);
    wait_active(1'b0, 8);
    host_read(`GSU_ADDR_SFR, b);
    check_val("SFR.GO", 16'(b[5]), 16'h0);

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* gsu.f */
+incdir+verilog
verilog/gsu_pkg.sv
verilog/gsu_cache.sv
verilog/gsu_regs.sv
verilog/gsu_decode.sv
verilog/gsu_execute.sv
verilog/gsu_result.sv
verilog/gsu.sv
bench/gsu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary -j 0 --timescale 1ns/100ps
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/100ps
TOP        = gsu_tb
RTL_TOP    = gsu
FILELIST   = gsu.f
BUILD_DIR  = obj_dir
LOG        = sim.log
SRCS       = $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint clean

all: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || { echo "Simulation did not finish"; exit 1; }

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
